//--- design/dm_config.svh
`ifndef DM_CONFIG_SVH
`define DM_CONFIG_SVH

// bus widths
`define DM_ADDR_W 8
`define DM_DATA_W 32

// message register counts and first word addresses
`define DM_NUM_DATA 12
`define DM_NUM_PROGBUF 16
`define DM_DATA_BASE 8'h04
`define DM_PROGBUF_BASE 8'h20

// debug spec 0.13, reported in dmstatus.version
`define DM_VERSION 4'd2
`define DM_NUM_HARTS 1
`define DM_HARTSEL_W 10

// dmcontrol field positions
`define DM_CTRL_DMACTIVE 0
`define DM_CTRL_NDMRESET 1
`define DM_CTRL_HARTSEL_LO 16
`define DM_CTRL_ACKHAVERESET 28
`define DM_CTRL_HARTRESET 29

// dmstatus bit positions
`define DM_STAT_AUTH 7
`define DM_STAT_ANYNONEX 14
`define DM_STAT_ALLNONEX 15
`define DM_STAT_ANYHAVERESET 18
`define DM_STAT_ALLHAVERESET 19

`endif

//--- design/dm_pkg.sv
`include "dm_config.svh"

package dm_pkg;

	// addresses of the registers held in dm_ctrl
	// data and progbuf are decoded as ranges in dm_data_regs
	typedef enum logic [`DM_ADDR_W-1:0] {
		DM_DMCONTROL = 8'h10,
		DM_DMSTATUS  = 8'h11
	} dm_reg_e;

	// bresp / rresp encoding
	// only okay is ever returned
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	// write channel engine
	// idle: wait for aw and w together
	// accept: ready pulse, register strobe
	// resp: bvalid held until bready
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ACCEPT,
		WR_RESP
	} wr_state_e;

	// read channel engine
	// idle: wait for arvalid
	// accept: arready pulse, rdata sampled
	// resp: rvalid held until rready
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ACCEPT,
		RD_RESP
	} rd_state_e;

endpackage

//--- design/axil_slave.sv
`timescale 1ns/1ps
`include "dm_config.svh"

module axil_slave (
	input  logic CLK,
	input  logic RSTn,
	// write address / data
	input  logic [`DM_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`DM_DATA_W-1:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	// write response
	output dm_pkg::axi_resp_e bresp,
	output logic bvalid,
	input  logic bready,
	// read address / data
	input  logic [`DM_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [`DM_DATA_W-1:0] rdata,
	output dm_pkg::axi_resp_e rresp,
	output logic rvalid,
	input  logic rready,
	// register side
	output logic wr_en,
	output logic [`DM_ADDR_W-1:0] wr_addr,
	output logic [`DM_DATA_W-1:0] wr_data,
	output logic [`DM_ADDR_W-1:0] rd_addr,
	input  logic [`DM_DATA_W-1:0] rd_data
);
	import dm_pkg::*;

	wr_state_e wr_state;
	rd_state_e rd_state;

	// write engine
	// aw and w are taken together, one write outstanding
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			wr_state <= WR_IDLE;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (awvalid && wvalid) begin
						wr_state <= WR_ACCEPT;
					end
				end
				WR_ACCEPT: begin
					wr_state <= WR_RESP;
				end
				WR_RESP: begin
					if (bready) begin
						wr_state <= WR_IDLE;
					end
				end
				default: begin
					wr_state <= WR_IDLE;
				end
			endcase
		end
	end

	// address and data latched as both valids are seen
	// strobes are not decoded, whole words only
	always_ff @(posedge CLK) begin
		if (wr_state == WR_IDLE && awvalid && wvalid) begin
			wr_addr <= awaddr;
			wr_data <= wdata;
		end
	end

	// ready pulse and register strobe share the accept cycle
	assign awready = (wr_state == WR_ACCEPT);
	assign wready  = (wr_state == WR_ACCEPT);
	assign wr_en   = (wr_state == WR_ACCEPT);
	assign bvalid  = (wr_state == WR_RESP);
	assign bresp   = RESP_OKAY;

	// read engine, runs alongside the write engine
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (arvalid) begin
						rd_state <= RD_ACCEPT;
					end
				end
				RD_ACCEPT: begin
					rd_state <= RD_RESP;
				end
				RD_RESP: begin
					if (rready) begin
						rd_state <= RD_IDLE;
					end
				end
				default: begin
					rd_state <= RD_IDLE;
				end
			endcase
		end
	end

	// rd_addr held until the next accept
	// rdata sampled at the end of accept, so a same-cycle write is not seen
	always_ff @(posedge CLK) begin
		if (rd_state == RD_IDLE && arvalid) begin
			rd_addr <= araddr;
		end
		if (rd_state == RD_ACCEPT) begin
			rdata <= rd_data;
		end
	end

	assign arready = (rd_state == RD_ACCEPT);
	assign rvalid  = (rd_state == RD_RESP);
	assign rresp   = RESP_OKAY;

	// ready pulse lands while the master still holds both valids
	a_wr_handshake: assert property (@(posedge CLK) disable iff (!RSTn)
		awready |-> (wready && awvalid && wvalid))
		else $error("write ready pulse without a full aw/w handshake");

	a_bvalid_hold: assert property (@(posedge CLK) disable iff (!RSTn)
		(bvalid && !bready) |=> bvalid)
		else $error("bvalid dropped before bready");

	a_rdata_hold: assert property (@(posedge CLK) disable iff (!RSTn)
		(rvalid && !rready) |=> (rvalid && $stable(rdata)))
		else $error("rvalid or rdata changed before rready");

endmodule

//--- design/dm_ctrl.sv
`timescale 1ns/1ps
`include "dm_config.svh"

module dm_ctrl #(
	parameter int num_harts = `DM_NUM_HARTS
) (
	input  logic CLK,
	input  logic RSTn,
	input  logic wr_en,
	input  logic [`DM_ADDR_W-1:0] wr_addr,
	input  logic [`DM_DATA_W-1:0] wr_data,
	input  logic [`DM_ADDR_W-1:0] rd_addr,
	input  logic [`DM_DATA_W-1:0] data_rd_data,
	output logic [`DM_DATA_W-1:0] rd_data,
	output logic dmactive,
	output logic ndmreset,
	output logic ndmresetn,
	output logic [num_harts-1:0] hart_reset
);
	import dm_pkg::*;

	localparam int hsel_w = `DM_HARTSEL_W;

	logic ctrl_wr;
	logic deactivate;
	logic ack_wr;
	logic hartreset_q;
	logic [hsel_w-1:0] hartsel_q;
	logic [hsel_w-1:0] hartsel_wr;
	logic [num_harts-1:0] havereset_q;
	logic [num_harts-1:0] sel_hit;
	logic [num_harts-1:0] ack_hit;
	logic sel_exists;
	logic sel_havereset;
	logic [`DM_DATA_W-1:0] dmcontrol_rd;
	logic [`DM_DATA_W-1:0] dmstatus_rd;

	assign ctrl_wr    = wr_en && (wr_addr == DM_DMCONTROL);
	assign hartsel_wr = wr_data[`DM_CTRL_HARTSEL_LO +: hsel_w];
	// inactive now, or this write turns the module off
	assign deactivate = !dmactive || (ctrl_wr && !wr_data[`DM_CTRL_DMACTIVE]);
	// ack only honoured while active
	assign ack_wr = ctrl_wr && dmactive && wr_data[`DM_CTRL_ACKHAVERESET];

	// dmcontrol fields
	// dmactive is the only field that loads while inactive
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			dmactive    <= 1'b0;
			ndmreset    <= 1'b0;
			hartreset_q <= 1'b0;
			hartsel_q   <= '0;
		end else begin
			if (ctrl_wr) begin
				dmactive <= wr_data[`DM_CTRL_DMACTIVE];
			end
			if (deactivate) begin
				ndmreset    <= 1'b0;
				hartreset_q <= 1'b0;
				hartsel_q   <= '0;
			end else if (ctrl_wr) begin
				ndmreset    <= wr_data[`DM_CTRL_NDMRESET];
				hartreset_q <= wr_data[`DM_CTRL_HARTRESET];
				hartsel_q   <= hartsel_wr;
			end
		end
	end

	assign ndmresetn = !ndmreset;

	// per hart select decode
	// ack matches against the hartsel carried by the same write
	for (genvar i = 0; i < num_harts; i++) begin : g_hart
		localparam logic [hsel_w-1:0] hart_idx = hsel_w'(i);
		assign sel_hit[i] = (hartsel_q == hart_idx);
		assign ack_hit[i] = ack_wr && (hartsel_wr == hart_idx);
	end

	assign hart_reset = sel_hit & {num_harts{hartreset_q}};

	// havereset set while the hart is held in reset, cleared by ack
	// a held reset wins over an ack in the same cycle
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			havereset_q <= '1;
		end else begin
			havereset_q <= (havereset_q & ~ack_hit) | hart_reset;
		end
	end

	// index at or above num_harts hits nothing
	assign sel_exists    = |sel_hit;
	assign sel_havereset = |(havereset_q & sel_hit);

	// dmcontrol readback, ackhavereset always reads 0
	always_comb begin
		dmcontrol_rd = '0;
		dmcontrol_rd[`DM_CTRL_DMACTIVE] = dmactive;
		dmcontrol_rd[`DM_CTRL_NDMRESET] = ndmreset;
		dmcontrol_rd[`DM_CTRL_HARTRESET] = hartreset_q;
		dmcontrol_rd[`DM_CTRL_HARTSEL_LO +: hsel_w] = hartsel_q;
	end

	// dmstatus, single hart selected so any and all agree
	always_comb begin
		dmstatus_rd = '0;
		dmstatus_rd[3:0] = `DM_VERSION;
		dmstatus_rd[`DM_STAT_AUTH] = 1'b1;
		dmstatus_rd[`DM_STAT_ANYNONEX] = !sel_exists;
		dmstatus_rd[`DM_STAT_ALLNONEX] = !sel_exists;
		dmstatus_rd[`DM_STAT_ANYHAVERESET] = sel_havereset;
		dmstatus_rd[`DM_STAT_ALLHAVERESET] = sel_havereset;
	end

	// final read word
	// storage block already returns 0 off its ranges
	always_comb begin
		case (rd_addr)
			DM_DMCONTROL: rd_data = dmcontrol_rd;
			DM_DMSTATUS:  rd_data = dmstatus_rd;
			default:      rd_data = data_rd_data;
		endcase
	end

	a_hart_reset_onehot: assert property (@(posedge CLK) disable iff (!RSTn)
		$onehot0(hart_reset))
		else $error("more than one hart_reset line high");

	a_hart_reset_active: assert property (@(posedge CLK) disable iff (!RSTn)
		(|hart_reset) |-> dmactive)
		else $error("hart_reset high while dmactive is low");

endmodule

//--- design/dm_data_regs.sv
`timescale 1ns/1ps
`include "dm_config.svh"

module dm_data_regs (
	input  logic CLK,
	input  logic RSTn,
	input  logic dmactive,
	input  logic wr_en,
	input  logic [`DM_ADDR_W-1:0] wr_addr,
	input  logic [`DM_DATA_W-1:0] wr_data,
	input  logic [`DM_ADDR_W-1:0] rd_addr,
	output logic [`DM_DATA_W-1:0] data_rd_data
);

	localparam int num_words = `DM_NUM_DATA + `DM_NUM_PROGBUF;
	localparam int idx_w = $clog2(num_words);

	// data words first, progbuf words after them
	logic [`DM_DATA_W-1:0] words [num_words];

	// true inside data0..dataN or progbuf0..progbufN
	function automatic logic is_mapped(input logic [`DM_ADDR_W-1:0] addr);
		logic in_data;
		logic in_progbuf;
		in_data = (addr >= `DM_DATA_BASE) && (addr < (`DM_DATA_BASE + `DM_NUM_DATA));
		in_progbuf = (addr >= `DM_PROGBUF_BASE) &&
			(addr < (`DM_PROGBUF_BASE + `DM_NUM_PROGBUF));
		return in_data || in_progbuf;
	endfunction

	// array slot of a mapped address
	function automatic logic [idx_w-1:0] word_idx(input logic [`DM_ADDR_W-1:0] addr);
		if (addr < `DM_PROGBUF_BASE) begin
			return idx_w'(addr - `DM_DATA_BASE);
		end
		return idx_w'(addr - `DM_PROGBUF_BASE + `DM_NUM_DATA);
	endfunction

	// bulk clear while inactive, so plain flops and not a ram
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			for (int i = 0; i < num_words; i++) begin
				words[i] <= '0;
			end
		end else if (!dmactive) begin
			for (int i = 0; i < num_words; i++) begin
				words[i] <= '0;
			end
		end else if (wr_en && is_mapped(wr_addr)) begin
			words[word_idx(wr_addr)] <= wr_data;
		end
	end

	// no read latency
	// unmapped addresses give 0 so dm_ctrl can pass this through
	always_comb begin
		if (is_mapped(rd_addr)) begin
			data_rd_data = words[word_idx(rd_addr)];
		end else begin
			data_rd_data = '0;
		end
	end

endmodule

//--- design/dm_top.sv
`timescale 1ns/1ps
`include "dm_config.svh"

module dm_top #(
	parameter int num_harts = `DM_NUM_HARTS
) (
	input  logic CLK,
	input  logic RSTn,
	input  logic [`DM_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`DM_DATA_W-1:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output dm_pkg::axi_resp_e bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`DM_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [`DM_DATA_W-1:0] rdata,
	output dm_pkg::axi_resp_e rresp,
	output logic rvalid,
	input  logic rready,
	// core control
	output logic ndmreset,
	output logic ndmresetn,
	output logic dmactive,
	output logic [num_harts-1:0] hart_reset
);

	// register access from the bus engine
	logic wr_en;
	logic [`DM_ADDR_W-1:0] wr_addr;
	logic [`DM_DATA_W-1:0] wr_data;
	logic [`DM_ADDR_W-1:0] rd_addr;
	// dm_ctrl final word, and storage range word into dm_ctrl
	logic [`DM_DATA_W-1:0] rd_data;
	logic [`DM_DATA_W-1:0] data_rd_data;

	axil_slave axil_i (
		.CLK, .RSTn,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.wr_en, .wr_addr, .wr_data,
		.rd_addr, .rd_data
	);

	dm_ctrl #(.num_harts(num_harts)) ctrl_i (
		.CLK, .RSTn,
		.wr_en, .wr_addr, .wr_data,
		.rd_addr, .data_rd_data, .rd_data,
		.dmactive, .ndmreset, .ndmresetn, .hart_reset
	);

	// storage is held clear by dmactive from dm_ctrl
	dm_data_regs data_i (
		.CLK, .RSTn,
		.dmactive,
		.wr_en, .wr_addr, .wr_data,
		.rd_addr, .data_rd_data
	);

endmodule

//--- tests/dm_tb_tasks.svh
`ifndef DM_TB_TASKS_SVH
`define DM_TB_TASKS_SVH

// report one failure and stop the run
task automatic abort_run(input string what);
	$display("%s", what);
	$display("Errors found");
	$fatal(1, "simulation stopped");
endtask

// one clock of a bounded wait
task automatic tick_or_timeout(inout int cycles, input string what);
	@(posedge CLK);
	cycles++;
	if (cycles > timeout_cycles) begin
		abort_run($sformatf("timeout at %0t: %s never arrived", $time, what));
	end
endtask

task automatic check_word(input string name, input logic [`DM_DATA_W-1:0] exp,
	input logic [`DM_DATA_W-1:0] act);
	if (act !== exp) begin
		abort_run($sformatf("Error at %0t: %s expected %h, got %h", $time, name, exp, act));
	end
endtask

task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
	if (act !== exp) begin
		abort_run($sformatf("Error at %0t: %s expected %b, got %b", $time, name, exp, act));
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		abort_run($sformatf("Error at %0t: %s expected %b, got %b", $time, name, exp, act));
	end
endtask

// aw and w together, then bready after a random delay
task automatic axi_write(input logic [`DM_ADDR_W-1:0] addr, input logic [`DM_DATA_W-1:0] data);
	int cycles;
	int delay;
	delay = int'($urandom_range(3, 0));
	@(posedge CLK);
	awaddr <= addr;
	awvalid <= 1'b1;
	wdata <= data;
	wstrb <= 4'hf;
	wvalid <= 1'b1;
	cycles = 0;
	do begin
		tick_or_timeout(cycles, "awready and wready of a write");
	end while (!(awready && wready));
	awvalid <= 1'b0;
	wvalid <= 1'b0;
	cycles = 0;
	do begin
		tick_or_timeout(cycles, "bvalid of a write");
	end while (!bvalid);
	// back-pressure, bvalid has to stay up
	repeat (delay) begin
		@(posedge CLK);
		check_bit("bvalid", 1'b1, bvalid);
	end
	bready <= 1'b1;
	@(posedge CLK);
	check_bit("bvalid", 1'b1, bvalid);
	check_resp("bresp", RESP_OKAY, bresp);
	bready <= 1'b0;
endtask

// address phase, then rready after a random delay
task automatic axi_read(input logic [`DM_ADDR_W-1:0] addr, output logic [`DM_DATA_W-1:0] data);
	int cycles;
	int delay;
	logic [`DM_DATA_W-1:0] first;
	delay = int'($urandom_range(3, 0));
	@(posedge CLK);
	araddr <= addr;
	arvalid <= 1'b1;
	cycles = 0;
	do begin
		tick_or_timeout(cycles, "arready of a read");
	end while (!arready);
	arvalid <= 1'b0;
	cycles = 0;
	do begin
		tick_or_timeout(cycles, "rvalid of a read");
	end while (!rvalid);
	first = rdata;
	// rvalid and rdata held while rready is low
	repeat (delay) begin
		@(posedge CLK);
		check_bit("rvalid", 1'b1, rvalid);
		check_word("rdata while held", first, rdata);
	end
	rready <= 1'b1;
	@(posedge CLK);
	check_bit("rvalid", 1'b1, rvalid);
	check_word("rdata while held", first, rdata);
	check_resp("rresp", RESP_OKAY, rresp);
	data = rdata;
	rready <= 1'b0;
endtask

`endif

//--- tests/dm_tb.sv
`timescale 1ns/1ps
`include "dm_config.svh"

module dm_tb;
	import dm_pkg::*;

	localparam int num_harts = 2;
	localparam int max_cmds = 128;
	localparam int timeout_cycles = 50;

	logic CLK;
	logic RSTn;
	logic [`DM_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`DM_DATA_W-1:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	axi_resp_e bresp;
	logic bvalid;
	logic bready;
	logic [`DM_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`DM_DATA_W-1:0] rdata;
	axi_resp_e rresp;
	logic rvalid;
	logic rready;
	logic ndmreset;
	logic ndmresetn;
	logic dmactive;
	logic [num_harts-1:0] hart_reset;

	// op, address, data packed per command word
	logic [4+`DM_ADDR_W+`DM_DATA_W-1:0] cmds [max_cmds];

	`include "dm_tb_tasks.svh"

	dm_top #(.num_harts(num_harts)) dut_i (
		.CLK, .RSTn,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.ndmreset, .ndmresetn, .dmactive, .hart_reset
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	initial begin
		int i;
		logic [3:0] op;
		logic [`DM_ADDR_W-1:0] addr;
		logic [`DM_DATA_W-1:0] val;
		logic [`DM_DATA_W-1:0] got;
		void'($urandom(32'hfedb));
		RSTn = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		// op 0 marks the end of the list
		for (i = 0; i < max_cmds; i++) begin
			cmds[i] = '0;
		end
		$readmemh("tests/dm_tests.txt", cmds);
		repeat (5) @(posedge CLK);
		RSTn <= 1'b1;
		i = 0;
		while (i < max_cmds && cmds[i][4+`DM_ADDR_W+`DM_DATA_W-1 -: 4] != 4'h0) begin
			{op, addr, val} = cmds[i];
			case (op)
				4'h1: axi_write(addr, val);
				4'h2: begin
					axi_read(addr, got);
					check_word($sformatf("rdata of 0x%02h", addr), val, got);
				end
				4'h3: begin
					// ports settle a cycle after the last write response
					@(posedge CLK);
					check_bit("ndmreset", val[4], ndmreset);
					check_bit("ndmresetn", val[3], ndmresetn);
					check_bit("dmactive", val[2], dmactive);
					check_bit("hart_reset[1]", val[1], hart_reset[1]);
					check_bit("hart_reset[0]", val[0], hart_reset[0]);
				end
				default: abort_run($sformatf("command %0d has unknown op %h", i, op));
			endcase
			i++;
		end
		if (i == 0) begin
			abort_run("command file is empty or missing");
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

//--- tests/dm_tests.txt
// each word is op_addr_data, op 1 write, 2 read and compare, 3 port check
// port check data is {ndmreset, ndmresetn, dmactive, hart_reset[1], hart_reset[0]}
// after reset: inactive ports, empty storage, dmstatus with havereset
3_00_00000008 2_04_00000000 2_20_00000000 2_11_000c0082
// write while inactive is dropped
1_04_deadbeef 2_04_00000000
// activate
1_10_00000001 3_00_0000000c
// data0..data11
1_04_c0de0004 1_05_c0de0005 1_06_c0de0006 1_07_c0de0007 1_08_c0de0008 1_09_c0de0009
1_0a_c0de000a 1_0b_c0de000b 1_0c_c0de000c 1_0d_c0de000d 1_0e_c0de000e 1_0f_c0de000f
// progbuf0..progbuf15
1_20_feed0020 1_21_feed0021 1_22_feed0022 1_23_feed0023 1_24_feed0024 1_25_feed0025
1_26_feed0026 1_27_feed0027 1_28_feed0028 1_29_feed0029 1_2a_feed002a 1_2b_feed002b
1_2c_feed002c 1_2d_feed002d 1_2e_feed002e 1_2f_feed002f
2_04_c0de0004 2_05_c0de0005 2_06_c0de0006 2_07_c0de0007 2_08_c0de0008 2_09_c0de0009
2_0a_c0de000a 2_0b_c0de000b 2_0c_c0de000c 2_0d_c0de000d 2_0e_c0de000e 2_0f_c0de000f
2_20_feed0020 2_21_feed0021 2_22_feed0022 2_23_feed0023 2_24_feed0024 2_25_feed0025
2_26_feed0026 2_27_feed0027 2_28_feed0028 2_29_feed0029 2_2a_feed002a 2_2b_feed002b
2_2c_feed002c 2_2d_feed002d 2_2e_feed002e 2_2f_feed002f
// unmapped addresses
2_17_00000000 2_38_00000000
// ndmreset, hartreset on hart 1, then both cleared
1_10_00000003 3_00_00000014 1_10_20010001 3_00_0000000e 1_10_00000001 3_00_0000000c
// ack hart 0, pulse its reset, select a missing hart
1_10_10000001 2_11_00000082 1_10_20000001 1_10_00000001 2_11_000c0082
1_10_00050001 2_11_0000c082 2_10_00050001
// deactivate with resets held
1_10_20010003 3_00_00000016 1_10_00000000 3_00_00000008 2_10_00000000
2_04_00000000 2_0f_00000000 2_20_00000000 2_2f_00000000

//--- sources.f
+incdir+design
+incdir+tests
design/dm_pkg.sv
design/axil_slave.sv
design/dm_ctrl.sv
design/dm_data_regs.sv
design/dm_top.sv
tests/dm_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the debug module testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dm_tb -f sources.f -o dm_sim \
	&& ./obj_dir/dm_sim | tee sim.log \
	&& grep -qx "No errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
